/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_host_msg_bridge
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall -Wno-fatal
PASS_MSG   := Simulation completed successfully

SOURCES := $(wildcard logic/*.sv tb/*.sv tb/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
logic/msg_pkg.sv
logic/msg_fifo.sv
logic/msg_sequencer.sv
logic/frame_reducer.sv
logic/host_msg_bridge.sv
+incdir+tb
tb/tb_host_msg_bridge.sv

/* logic/frame_reducer.sv */
`timescale 1ns/1ps

module frame_reducer (
  input  logic                        bus_clk,
  input  logic                        rst,
  input  logic [msg_pkg::FP_W-1:0]    smp_pixel,
  input  logic [msg_pkg::FP_W-1:0]    smp_coeff,
  input  logic [msg_pkg::KIND_W-1:0]  smp_kind,
  input  logic                        smp_valid,
  output logic                        smp_ready,
  input  logic                        rd_open,
  output logic [msg_pkg::SUM_W-1:0]   res_data,
  output logic                        res_valid,
  input  logic                        res_ready
);

  logic                        stall;
  logic                        s1_valid;
  logic [msg_pkg::KIND_W-1:0]  s1_kind;
  logic [msg_pkg::PROD_W-1:0]  s1_prod;
  logic [msg_pkg::SUM_W-1:0]   sum;
  logic                        pending;
  logic                        s2_go;
  logic                        flush;

  // Whole pipe freezes while a result waits on the queue
  assign stall     = res_valid && !res_ready;
  assign smp_ready = !stall;

  assign s2_go = s1_valid && !stall;
  // Frame end and session end both flush, but only with a sample pending
  assign flush = s2_go && (s1_kind != msg_pkg::KIND_ACC) && pending;

  // ******************************
  // Stage 1, multiply
  // ******************************

  always_ff @(posedge bus_clk or posedge rst) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid <= smp_valid;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (!stall && smp_valid) begin
      s1_kind <= smp_kind;
      s1_prod <= smp_pixel * smp_coeff;
    end
  end

  // ******************************
  // Stage 2, accumulate and flush
  // ******************************

  always_ff @(posedge bus_clk or posedge rst) begin
    if (rst) begin
      sum       <= '0;
      pending   <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      if (res_ready) begin
        res_valid <= 1'b0;
      end
      if (s2_go && (s1_kind == msg_pkg::KIND_ACC)) begin
        // Sum wraps at 2^32, so only the low product bits matter
        sum     <= sum + s1_prod[msg_pkg::SUM_W-1:0];
        pending <= 1'b1;
      end else if (flush) begin
        sum     <= '0;
        pending <= 1'b0;
        // Closed read channel drops the result here
        res_valid <= rd_open;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (flush) begin
      res_data <= sum;
    end
  end

endmodule

/* logic/host_msg_bridge.sv */
`timescale 1ns/1ps

module host_msg_bridge (
  input  logic                      bus_clk,
  input  logic                      rst,
  // Write channel, host to design
  input  logic [msg_pkg::MSG_W-1:0] wr_data,
  input  logic                      wr_valid,
  output logic                      wr_ready,
  input  logic                      wr_open,
  // Read channel, results to host
  output logic [msg_pkg::MSG_W-1:0] rd_data,
  output logic                      rd_valid,
  input  logic                      rd_ready,
  input  logic                      rd_open,
  output logic                      rd_eof,
  // Loopback channel
  output logic [msg_pkg::MSG_W-1:0] loop_data,
  output logic                      loop_valid,
  input  logic                      loop_ready,
  output logic                      loop_eof
);

  logic [msg_pkg::MSG_W-1:0]   in_data;
  logic                        in_valid;
  logic                        in_ready;
  logic [msg_pkg::MSG_W-1:0]   echo_data;
  logic                        echo_valid;
  logic                        echo_ready;
  logic [msg_pkg::FP_W-1:0]    smp_pixel;
  logic [msg_pkg::FP_W-1:0]    smp_coeff;
  logic [msg_pkg::KIND_W-1:0]  smp_kind;
  logic                        smp_valid;
  logic                        smp_ready;
  logic [msg_pkg::SUM_W-1:0]   res_data;
  logic                        res_valid;
  logic                        res_ready;
  logic                        session_done;
  logic                        loop_empty;
  logic                        res_empty;

  // ******************************
  // Pipeline
  // ******************************

  msg_fifo u_ingress (
    .bus_clk(bus_clk), .rst(rst),
    .in_data(wr_data), .in_valid(wr_valid), .in_ready(wr_ready),
    .out_data(in_data), .out_valid(in_valid), .out_ready(in_ready),
    .empty()
  );

  msg_sequencer u_sequencer (
    .bus_clk(bus_clk), .rst(rst),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .echo_data(echo_data), .echo_valid(echo_valid), .echo_ready(echo_ready),
    .smp_pixel(smp_pixel), .smp_coeff(smp_coeff), .smp_kind(smp_kind),
    .smp_valid(smp_valid), .smp_ready(smp_ready),
    .session_done(session_done)
  );

  frame_reducer u_reducer (
    .bus_clk(bus_clk), .rst(rst),
    .smp_pixel(smp_pixel), .smp_coeff(smp_coeff), .smp_kind(smp_kind),
    .smp_valid(smp_valid), .smp_ready(smp_ready), .rd_open(rd_open),
    .res_data(res_data), .res_valid(res_valid), .res_ready(res_ready)
  );

  msg_fifo u_result (
    .bus_clk(bus_clk), .rst(rst),
    .in_data(res_data), .in_valid(res_valid), .in_ready(res_ready),
    .out_data(rd_data), .out_valid(rd_valid), .out_ready(rd_ready),
    .empty(res_empty)
  );

  // Side branch, every consumed word goes back out
  msg_fifo u_loopback (
    .bus_clk(bus_clk), .rst(rst),
    .in_data(echo_data), .in_valid(echo_valid), .in_ready(echo_ready),
    .out_data(loop_data), .out_valid(loop_valid), .out_ready(loop_ready),
    .empty(loop_empty)
  );

  // End-of-file flags
  assign rd_eof   = session_done && res_empty;
  assign loop_eof = !wr_open && loop_empty;

endmodule

/* logic/msg_fifo.sv */
`timescale 1ns/1ps

module msg_fifo (
  input  logic                      bus_clk,
  input  logic                      rst,
  input  logic [msg_pkg::MSG_W-1:0] in_data,
  input  logic                      in_valid,
  output logic                      in_ready,
  output logic [msg_pkg::MSG_W-1:0] out_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic                      empty
);

  logic [msg_pkg::MSG_W-1:0]   mem [msg_pkg::FIFO_DEPTH];
  logic [msg_pkg::FIFO_AW-1:0] wr_ptr;
  logic [msg_pkg::FIFO_AW-1:0] rd_ptr;
  logic [msg_pkg::FIFO_AW:0]   count;
  logic                        push;
  logic                        pop;

  // Full only when every entry holds a word
  assign in_ready  = (count != (msg_pkg::FIFO_AW + 1)'(msg_pkg::FIFO_DEPTH));
  assign empty     = (count == '0);
  assign out_valid = !empty;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Head word falls through, no read cycle needed
  assign out_data = mem[rd_ptr];

  // ******************************
  // Storage
  // ******************************

  always_ff @(posedge bus_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // ******************************
  // Pointers and occupancy
  // ******************************

  always_ff @(posedge bus_clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* logic/msg_pkg.sv */
package msg_pkg;

  // ******************************
  // Word and datapath widths
  // ******************************

  localparam int MSG_W  = 32;
  localparam int FP_W   = 20;
  localparam int SUM_W  = 32;
  localparam int PROD_W = 40;
  localparam int RSV_W  = MSG_W - FP_W;

  // Reducer taps, one coefficient each
  localparam int N_TAPS = 8;
  localparam int TAP_W  = 3;
  localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(N_TAPS - 1);

  // Queue geometry, shared by all three queues
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;

  // All-ones word closes a session in the data phase
  localparam logic [MSG_W-1:0] END_MARKER = '1;

  // ******************************
  // Sequencer to reducer item kinds
  // ******************************

  localparam int KIND_W = 2;
  localparam logic [KIND_W-1:0] KIND_ACC     = 2'd0;
  localparam logic [KIND_W-1:0] KIND_FRAME   = 2'd1;
  localparam logic [KIND_W-1:0] KIND_SESSION = 2'd2;

  // Host word, read as a coefficient or as a pixel sample
  typedef union packed {
    struct packed {
      logic [RSV_W-1:0] rsvd;
      logic [FP_W-1:0]  coeff;
    } coef;
    struct packed {
      logic             fval;
      logic [RSV_W-2:0] rsvd;
      logic [FP_W-1:0]  pixel;
    } smp;
  } msg_word_t;

endpackage

/* logic/msg_sequencer.sv */
`timescale 1ns/1ps

module msg_sequencer (
  input  logic                        bus_clk,
  input  logic                        rst,
  input  msg_pkg::msg_word_t          in_data,
  input  logic                        in_valid,
  output logic                        in_ready,
  output msg_pkg::msg_word_t          echo_data,
  output logic                        echo_valid,
  input  logic                        echo_ready,
  output logic [msg_pkg::FP_W-1:0]    smp_pixel,
  output logic [msg_pkg::FP_W-1:0]    smp_coeff,
  output logic [msg_pkg::KIND_W-1:0]  smp_kind,
  output logic                        smp_valid,
  input  logic                        smp_ready,
  output logic                        session_done
);

  logic                       coef_phase;
  logic [msg_pkg::TAP_W-1:0]  tap_idx;
  logic [msg_pkg::FP_W-1:0]   coeff_mem [msg_pkg::N_TAPS];
  logic                       echo_free;
  logic                       smp_free;
  logic                       accept;
  logic                       is_end;
  logic                       last_tap;

  // An output register is free when empty or draining this cycle
  assign echo_free = !echo_valid || echo_ready;
  assign smp_free  = !smp_valid || smp_ready;

  // Coefficient words only need room on the loopback side
  assign in_ready = echo_free && (coef_phase || smp_free);
  assign accept   = in_valid && in_ready;
  assign is_end   = (in_data == msg_pkg::END_MARKER);
  assign last_tap = (tap_idx == msg_pkg::LAST_TAP);

  // ******************************
  // Phase and tap index
  // ******************************

  always_ff @(posedge bus_clk or posedge rst) begin
    if (rst) begin
      coef_phase   <= 1'b1;
      tap_idx      <= '0;
      session_done <= 1'b0;
    end else if (accept) begin
      session_done <= 1'b0;
      if (coef_phase) begin
        // Same counter addresses the store while loading
        tap_idx <= last_tap ? '0 : tap_idx + 1'b1;
        if (last_tap) begin
          coef_phase <= 1'b0;
        end
      end else if (is_end) begin
        coef_phase   <= 1'b1;
        tap_idx      <= '0;
        session_done <= 1'b1;
      end else if (in_data.smp.fval) begin
        tap_idx <= last_tap ? '0 : tap_idx + 1'b1;
      end else begin
        tap_idx <= '0;
      end
    end
  end

  // Output valids
  always_ff @(posedge bus_clk or posedge rst) begin
    if (rst) begin
      echo_valid <= 1'b0;
      smp_valid  <= 1'b0;
    end else begin
      if (accept) begin
        echo_valid <= 1'b1;
      end else if (echo_ready) begin
        echo_valid <= 1'b0;
      end
      if (accept && !coef_phase) begin
        smp_valid <= 1'b1;
      end else if (smp_ready) begin
        smp_valid <= 1'b0;
      end
    end
  end

  // ******************************
  // Coefficient store and payloads
  // ******************************

  always_ff @(posedge bus_clk) begin
    if (accept && coef_phase) begin
      coeff_mem[tap_idx] <= in_data.coef.coeff;
    end
    if (accept) begin
      echo_data <= in_data;
    end
    if (accept && !coef_phase) begin
      smp_pixel <= in_data.smp.pixel;
      smp_coeff <= coeff_mem[tap_idx];
      if (is_end) begin
        smp_kind <= msg_pkg::KIND_SESSION;
      end else if (in_data.smp.fval) begin
        smp_kind <= msg_pkg::KIND_ACC;
      end else begin
        smp_kind <= msg_pkg::KIND_FRAME;
      end
    end
  end

endmodule

/* tb/host_model.svh */
`ifndef HOST_MODEL_SVH
`define HOST_MODEL_SVH

// ******************************
// Reference model of the bridge
// ******************************

// Sequencer and reducer state as seen from the host side
logic                      ref_coef_phase = 1'b1;
int                        ref_tap = 0;
logic [msg_pkg::FP_W-1:0]  ref_coeffs [msg_pkg::N_TAPS];
logic [msg_pkg::SUM_W-1:0] ref_sum = '0;
logic                      ref_pending = 1'b0;

// Random reserved bits above a random coefficient
function automatic logic [31:0] coeff_word();
  logic [31:0] w;
  w = $urandom;
  return w;
endfunction

// Random pixel and reserved bits under the fval flag
function automatic logic [31:0] sample_word(input logic fval);
  logic [31:0] w;
  w = $urandom;
  w[msg_pkg::MSG_W-1] = fval;
  return w;
endfunction

// Emit the running sum only if a sample went in since the last result
task automatic flush_sum(input logic keep);
  if (ref_pending) begin
    if (keep) begin
      exp_res.push_back(ref_sum);
    end
    ref_sum     = '0;
    ref_pending = 1'b0;
  end
endtask

// Every word is echoed; what else it does depends on the phase
task automatic predict_word(input logic [31:0] w, input logic keep);
  logic [63:0] prod;
  exp_loop.push_back(w);
  if (ref_coef_phase) begin
    ref_coeffs[ref_tap] = w[msg_pkg::FP_W-1:0];
    if (ref_tap == msg_pkg::N_TAPS - 1) begin
      ref_tap        = 0;
      ref_coef_phase = 1'b0;
    end else begin
      ref_tap++;
    end
  end else if (w == msg_pkg::END_MARKER) begin
    flush_sum(keep);
    ref_tap        = 0;
    ref_coef_phase = 1'b1;
  end else if (w[msg_pkg::MSG_W-1]) begin
    prod        = 64'(w[msg_pkg::FP_W-1:0]) * 64'(ref_coeffs[ref_tap]);
    ref_sum     = ref_sum + prod[msg_pkg::SUM_W-1:0];
    ref_pending = 1'b1;
    ref_tap     = (ref_tap + 1) % msg_pkg::N_TAPS;
  end else begin
    flush_sum(keep);
    ref_tap = 0;
  end
endtask

`endif

/* tb/tb_host_msg_bridge.sv */
`timescale 1ns/1ps

module tb_host_msg_bridge;

  localparam int unsigned SEED     = 32'h32111eff;
  localparam int CLK_NS            = 100;
  localparam int RESET_CYCLES      = 10;
  localparam int N_FRAMES          = 12;
  localparam int MAX_FRAME_LEN     = 12;
  localparam int N_BATCHES         = 4;
  localparam int DRAIN_LIMIT       = 4000;
  localparam int CYCLES_PER_WORD   = 60;
  // Worst case word count with coefficients and empty frames
  localparam int MAX_WORDS =
    N_BATCHES * (2 * msg_pkg::N_TAPS + N_FRAMES * (MAX_FRAME_LEN + 2) + 2);
  localparam longint TIMEOUT_NS = longint'(MAX_WORDS) * CYCLES_PER_WORD * CLK_NS;

  logic        bus_clk;
  logic        rst;
  logic [31:0] wr_data;
  logic        wr_valid;
  logic        wr_ready;
  logic        wr_open;
  logic [31:0] rd_data;
  logic        rd_valid;
  logic        rd_ready;
  logic        rd_open;
  logic        rd_eof;
  logic [31:0] loop_data;
  logic        loop_valid;
  logic        loop_ready;
  logic        loop_eof;

  logic [31:0] exp_loop [$];
  logic [31:0] exp_res [$];
  int          err_value = 0;
  int          err_other = 0;
  int          rd_stall = 0;
  int          loop_stall = 0;
  int          gap_pct = 0;
  logic        wr_full_seen = 1'b0;
  string       test_name = "reset";

  `include "host_model.svh"

  host_msg_bridge i_dut (
    .bus_clk(bus_clk), .rst(rst),
    .wr_data(wr_data), .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_open(wr_open),
    .rd_data(rd_data), .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_open(rd_open),
    .rd_eof(rd_eof),
    .loop_data(loop_data), .loop_valid(loop_valid), .loop_ready(loop_ready),
    .loop_eof(loop_eof)
  );

  initial bus_clk = 1'b0;
  always #(CLK_NS / 2) bus_clk = ~bus_clk;

  // ******************************
  // Host readers with random stalls
  // ******************************

  // Each reader picks ready and checks the transfer on the falling edge
  initial begin
    logic [31:0] want;
    rd_ready = 1'b0;
    forever begin
      @(negedge bus_clk);
      rd_ready = (($urandom % 100) >= rd_stall);
      if (rd_valid && rd_ready) begin
        if (exp_res.size() == 0) begin
          $display("Unexpected result %h on the read channel in test %s", rd_data, test_name);
          err_other++;
        end else begin
          want = exp_res.pop_front();
          if (rd_data !== want) begin
            $display("** Error [%s] result expected %h, actual %h", test_name, want, rd_data);
            err_value++;
          end
        end
      end
    end
  end

  initial begin
    logic [31:0] want;
    loop_ready = 1'b0;
    forever begin
      @(negedge bus_clk);
      loop_ready = (($urandom % 100) >= loop_stall);
      if (loop_valid && loop_ready) begin
        if (exp_loop.size() == 0) begin
          $display("Unexpected loopback word %h in test %s", loop_data, test_name);
          err_other++;
        end else begin
          want = exp_loop.pop_front();
          if (loop_data !== want) begin
            $display("** Error [%s] loopback expected %h, actual %h", test_name, want,
                     loop_data);
            err_value++;
          end
        end
      end
    end
  end

  // ******************************
  // Writer tasks
  // ******************************

  task automatic send_word(input logic [31:0] w);
    logic taken;
    predict_word(w, rd_open);
    wr_data  = w;
    wr_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      taken = wr_ready;
      if (!wr_ready) begin
        wr_full_seen = 1'b1;
      end
      @(negedge bus_clk);
    end
    wr_valid = 1'b0;
    if (($urandom % 100) < gap_pct) begin
      @(negedge bus_clk);
    end
  endtask

  task automatic load_coeffs(input int n);
    for (int i = 0; i < n; i++) begin
      send_word(coeff_word());
    end
  endtask

  task automatic send_frame(input int len);
    for (int i = 0; i < len; i++) begin
      send_word(sample_word(1'b1));
    end
    send_word(sample_word(1'b0));
  endtask

  // Now and then a second fval-clear word that must yield nothing
  task automatic send_frames(input int n);
    for (int i = 0; i < n; i++) begin
      send_frame(1 + ($urandom % MAX_FRAME_LEN));
      if (($urandom % 4) == 0) begin
        send_word(sample_word(1'b0));
      end
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((exp_loop.size() != 0 || exp_res.size() != 0) && cycles < DRAIN_LIMIT) begin
      @(negedge bus_clk);
      cycles++;
    end
    if (cycles >= DRAIN_LIMIT) begin
      $display("Queues did not drain in test %s, %0d loopback and %0d results missing",
               test_name, exp_loop.size(), exp_res.size());
      err_other++;
    end
    // Reducer pipe settles behind the loopback echo
    repeat (8) @(negedge bus_clk);
  endtask

  // ******************************
  // Watchdog
  // ******************************

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired at %0t ns while in test %s", $time, test_name);
    $display("Simulation failed");
    $finish;
  end

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    void'($urandom(SEED));
    rst      = 1'b1;
    wr_data  = '0;
    wr_valid = 1'b0;
    wr_open  = 1'b1;
    rd_open  = 1'b1;
    repeat (RESET_CYCLES) @(negedge bus_clk);
    rst = 1'b0;
    @(negedge bus_clk);
    if (rd_valid || loop_valid || rd_eof || loop_eof || !wr_ready) begin
      $display("Outputs after reset are wrong, rd_valid %b loop_valid %b rd_eof %b",
               rd_valid, loop_valid, rd_eof);
      err_other++;
    end

    test_name = "frames";
    rd_stall   = 30;
    loop_stall = 30;
    gap_pct    = 25;
    load_coeffs(msg_pkg::N_TAPS);
    send_frames(N_FRAMES);
    wait_drained();

    test_name    = "burst";
    rd_stall     = 85;
    loop_stall   = 90;
    gap_pct      = 0;
    wr_full_seen = 1'b0;
    send_frames(N_FRAMES);
    wait_drained();
    if (!wr_full_seen) begin
      $display("wr_ready never fell during the burst");
      err_other++;
    end

    // Pending sum is flushed by the end marker itself
    test_name  = "restart";
    rd_stall   = 30;
    loop_stall = 30;
    gap_pct    = 25;
    for (int i = 0; i < 5; i++) begin
      send_word(sample_word(1'b1));
    end
    send_word(msg_pkg::END_MARKER);
    wait_drained();
    if (rd_eof !== 1'b1) begin
      $display("** Error [%s] rd_eof expected 1, actual %b", test_name, rd_eof);
      err_value++;
    end
    send_word(coeff_word());
    wait_drained();
    if (rd_eof !== 1'b0) begin
      $display("** Error [%s] rd_eof expected 0, actual %b", test_name, rd_eof);
      err_value++;
    end
    load_coeffs(msg_pkg::N_TAPS - 1);
    send_frames(N_FRAMES);
    wait_drained();

    test_name = "rd_closed";
    rd_open   = 1'b0;
    send_frames(N_FRAMES);
    wait_drained();
    rd_open = 1'b1;
    send_frame(msg_pkg::N_TAPS + 3);
    wait_drained();
    wr_open = 1'b0;
    wait_drained();
    if (loop_eof !== 1'b1) begin
      $display("** Error [%s] loop_eof expected 1, actual %b", test_name, loop_eof);
      err_value++;
    end

    $display("Error counts: %0d wrong values, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
